/* source/pce_pad_macros.svh */
// Pad port constants for the controller port and its host register map
`ifndef PCE_PAD_MACROS_SVH
`define PCE_PAD_MACROS_SVH

//////////////////////////////////////////////////
// Multitap geometry
//////////////////////////////////////////////////

// Ports behind the multitap
`define PAD_PORTS 5

//////////////////////////////////////////////////
// Host register map
//////////////////////////////////////////////////

// Byte spacing of the pad button registers
// Port n lives at n * stride
`define PAD_REG_STRIDE 4

// Tap and six-button enables
`define PAD_CFG_OFFSET 8'h14

//////////////////////////////////////////////////
// Console encoding
//////////////////////////////////////////////////

// Fourth slot of a six-button pad, marks the extended half
`define PAD_ID_NIBBLE 4'h0

`endif

/* source/axi_lite_pkg.sv */
// AXI4-Lite channel types and response codes for the host bus
package axi_lite_pkg;

	typedef logic [7:0]  axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [1:0]  axil_resp_t;

	localparam axil_resp_t resp_okay   = 2'b00;
	localparam axil_resp_t resp_slverr = 2'b10;

	// Valid rides inside each channel, ready stays a scalar
	typedef struct packed {
		logic       valid;
		axil_addr_t addr;
	} axil_aw_t;

	typedef struct packed {
		logic       valid;
		axil_data_t data;
	} axil_w_t;

	typedef struct packed {
		logic       valid;
		axil_resp_t resp;
	} axil_b_t;

	typedef struct packed {
		logic       valid;
		axil_addr_t addr;
	} axil_ar_t;

	typedef struct packed {
		logic       valid;
		axil_data_t data;
		axil_resp_t resp;
	} axil_r_t;

	// One request in flight at a time
	typedef enum logic [1:0] {
		st_idle,
		st_wresp,
		st_rresp
	} axil_state_e;

endpackage

/* source/pad_pkg.sv */
// Pad side types for button words, port data and scan control
package pad_pkg;

	// Host buttons, set bit means pressed
	// 0 right, 1 left, 2 down, 3 up
	// 4 I, 5 II, 6 Select, 7 Run
	// 8..11 III to VI
	typedef logic [11:0] pad_buttons_t;

	// Console pad word, active low, four nibble slots
	// Slot 0 Run/Select/II/I
	// Slot 1 left/down/right/up
	// Slot 2 VI..III
	// Slot 3 ID nibble
	typedef logic [15:0] pad_word_t;

	typedef logic [3:0] pad_nibble_t;

	// Multitap port index, values past the last port read as no pad
	typedef logic [2:0] port_idx_t;

	// Configuration register bits 1:0
	typedef struct packed {
		logic tap_en;
		logic six_en;
	} pad_cfg_t;

	// Console pad lines
	typedef struct packed {
		logic sel;
		logic clr;
	} scan_ctrl_t;

endpackage

/* source/pad_host_regs.sv */
// AXI4-Lite slave holding the five pad button registers and the pad configuration
`timescale 1ns/1ps
`include "pce_pad_macros.svh"

module pad_host_regs (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  axi_lite_pkg::axil_aw_t aw,
	output logic                   awready,
	input  axi_lite_pkg::axil_w_t  w,
	output logic                   wready,
	output axi_lite_pkg::axil_b_t  b,
	input  logic                   bready,
	input  axi_lite_pkg::axil_ar_t ar,
	output logic                   arready,
	output axi_lite_pkg::axil_r_t  r,
	input  logic                   rready,
	output pad_pkg::pad_buttons_t  pads [`PAD_PORTS],
	output pad_pkg::pad_cfg_t      cfg
);
	import axi_lite_pkg::*;
	import pad_pkg::*;

	axil_state_e state;
	axil_resp_t  resp_q;
	axil_data_t  rdata_q;
	axil_data_t  rd_data;
	logic        wr_accept;
	logic        rd_accept;
	logic        wr_pad_hit;
	logic        wr_cfg_hit;
	logic        rd_pad_hit;
	logic        rd_cfg_hit;
	port_idx_t   wr_idx;
	port_idx_t   rd_idx;

	function automatic logic is_pad_addr(input axil_addr_t addr);
		return (addr < `PAD_PORTS * `PAD_REG_STRIDE) && (addr % `PAD_REG_STRIDE == 0);
	endfunction

	function automatic port_idx_t pad_index(input axil_addr_t addr);
		return port_idx_t'(addr / `PAD_REG_STRIDE);
	endfunction

	//////////////////////////////////////////////////
	// Handshake
	//////////////////////////////////////////////////

	// Write wins a tie, nothing taken while a response waits
	assign wr_accept = (state == st_idle) && aw.valid && w.valid;
	assign rd_accept = (state == st_idle) && ar.valid && !wr_accept;

	assign awready = wr_accept;
	assign wready  = wr_accept;
	assign arready = rd_accept;

	assign b = '{valid: (state == st_wresp), resp: resp_q};
	assign r = '{valid: (state == st_rresp), data: rdata_q, resp: resp_q};

	// Address decode
	assign wr_pad_hit = is_pad_addr(aw.addr);
	assign wr_cfg_hit = (aw.addr == `PAD_CFG_OFFSET);
	assign wr_idx     = pad_index(aw.addr);
	assign rd_pad_hit = is_pad_addr(ar.addr);
	assign rd_cfg_hit = (ar.addr == `PAD_CFG_OFFSET);
	assign rd_idx     = pad_index(ar.addr);

	// Unmapped reads return zero
	always_comb begin
		rd_data = '0;
		if (rd_pad_hit) begin
			rd_data = {20'd0, pads[rd_idx]};
		end else if (rd_cfg_hit) begin
			rd_data = {30'd0, cfg};
		end
	end

	//////////////////////////////////////////////////
	// State and registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= st_idle;
			cfg   <= '0;
			for (int i = 0; i < `PAD_PORTS; i++) begin
				pads[i] <= '0;
			end
		end else begin
			case (state)
				st_idle: begin
					if (wr_accept) begin
						state <= st_wresp;
						if (wr_pad_hit) begin
							pads[wr_idx] <= w.data[11:0];
						end else if (wr_cfg_hit) begin
							cfg <= pad_cfg_t'(w.data[1:0]);
						end
					end else if (rd_accept) begin
						state <= st_rresp;
					end
				end
				st_wresp: begin
					if (bready) begin
						state <= st_idle;
					end
				end
				st_rresp: begin
					if (rready) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Response code and read data of the pending request
	always_ff @(posedge clk_sys) begin
		if (wr_accept) begin
			resp_q <= (wr_pad_hit || wr_cfg_hit) ? resp_okay : resp_slverr;
		end else if (rd_accept) begin
			resp_q  <= (rd_pad_hit || rd_cfg_hit) ? resp_okay : resp_slverr;
			rdata_q <= rd_data;
		end
	end

endmodule

/* source/pad_snapshot.sv */
// Remaps one port's host buttons into the console pad word and freezes it per scan
`timescale 1ns/1ps
`include "pce_pad_macros.svh"

module pad_snapshot (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  pad_pkg::pad_buttons_t buttons,
	input  logic                  capture,
	output pad_pkg::pad_word_t    word
);
	import pad_pkg::*;

	pad_word_t remap;

	//////////////////////////////////////////////////
	// Console layout
	//////////////////////////////////////////////////

	// Lines are active low on the console side
	always_comb begin
		remap[3:0]   = ~buttons[7:4];
		remap[7:4]   = ~{buttons[1], buttons[2], buttons[0], buttons[3]};
		remap[11:8]  = ~buttons[11:8];
		remap[15:12] = `PAD_ID_NIBBLE;
	end

	//////////////////////////////////////////////////
	// Scan snapshot
	//////////////////////////////////////////////////

	// Loaded once at the start of a scan
	// Host writes during the scan wait for the next one
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			word <= '1;
		end else if (capture) begin
			word <= remap;
		end
	end

endmodule

/* source/tap_scanner.sv */
// Multitap scanner that follows SEL/CLR and returns the selected pad nibble
`timescale 1ns/1ps
`include "pce_pad_macros.svh"

module tap_scanner (
	input  logic                clk_sys,
	input  logic                reset,
	input  pad_pkg::scan_ctrl_t scan,
	input  pad_pkg::pad_cfg_t   cfg,
	input  pad_pkg::pad_word_t  words [`PAD_PORTS],
	output logic                capture,
	output pad_pkg::pad_nibble_t nibble
);
	import pad_pkg::*;

	scan_ctrl_t scan_q;
	port_idx_t  port;
	logic       half;
	logic       clr_rise;
	logic       sel_rise;
	pad_word_t  port_word;

	//////////////////////////////////////////////////
	// Line edges
	//////////////////////////////////////////////////

	assign clr_rise = scan.clr && !scan_q.clr;
	assign sel_rise = scan.sel && !scan_q.sel;

	// Ports past the last one read as nothing pressed
	always_comb begin
		port_word = '1;
		if (port < `PAD_PORTS) begin
			port_word = words[port];
		end
	end

	//////////////////////////////////////////////////
	// Port and half tracking
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			scan_q  <= '0;
			port    <= '0;
			half    <= 1'b0;
			capture <= 1'b0;
			nibble  <= '0;
		end else begin
			scan_q  <= scan;
			capture <= clr_rise;

			if (scan.clr) begin
				port   <= '0;
				nibble <= '0;
				// Six-button pads flip halves on every scan
				if (clr_rise) begin
					half <= cfg.six_en ? !half : 1'b0;
				end
			end else begin
				// Stop at the first empty port so the index never wraps
				if (sel_rise && cfg.tap_en && (port < `PAD_PORTS)) begin
					port <= port + 3'd1;
				end
				// Slot is 2*half + SEL
				nibble <= port_word[{half, scan.sel, 2'b00} +: 4];
			end
		end
	end

endmodule

/* source/pce_pad_top.sv */
// Controller port top joining the host registers, the snapshots and the tap scanner
`timescale 1ns/1ps
`include "pce_pad_macros.svh"

module pce_pad_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  axi_lite_pkg::axil_aw_t aw,
	output logic                   awready,
	input  axi_lite_pkg::axil_w_t  w,
	output logic                   wready,
	output axi_lite_pkg::axil_b_t  b,
	input  logic                   bready,
	input  axi_lite_pkg::axil_ar_t ar,
	output logic                   arready,
	output axi_lite_pkg::axil_r_t  r,
	input  logic                   rready,
	input  pad_pkg::scan_ctrl_t    scan,
	output pad_pkg::pad_nibble_t   nibble
);
	import pad_pkg::*;

	pad_buttons_t pads [`PAD_PORTS];
	pad_word_t    words [`PAD_PORTS];
	pad_cfg_t     cfg;
	logic         capture;

	pad_host_regs u_pad_host_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.aw      (aw),
		.awready (awready),
		.w       (w),
		.wready  (wready),
		.b       (b),
		.bready  (bready),
		.ar      (ar),
		.arready (arready),
		.r       (r),
		.rready  (rready),
		.pads    (pads),
		.cfg     (cfg)
	);

	// One snapshot per multitap port
	generate
		for (genvar i = 0; i < `PAD_PORTS; i++) begin : g_snap
			pad_snapshot u_pad_snapshot (
				.clk_sys (clk_sys),
				.reset   (reset),
				.buttons (pads[i]),
				.capture (capture),
				.word    (words[i])
			);
		end
	endgenerate

	tap_scanner u_tap_scanner (
		.clk_sys (clk_sys),
		.reset   (reset),
		.scan    (scan),
		.cfg     (cfg),
		.words   (words),
		.capture (capture),
		.nibble  (nibble)
	);

endmodule

/* dv/pce_pad_tb.sv */
// Testbench for the controller port covering host register access and console pad scans
`timescale 1ns/1ps
`include "pce_pad_macros.svh"

module pce_pad_tb;
	import axi_lite_pkg::*;
	import pad_pkg::*;

	localparam int wait_limit = 50;

	logic         clk_sys;
	logic         reset;
	axil_aw_t     aw;
	logic         awready;
	axil_w_t      w;
	logic         wready;
	axil_b_t      b;
	logic         bready;
	axil_ar_t     ar;
	logic         arready;
	axil_r_t      r;
	logic         rready;
	scan_ctrl_t   scan;
	pad_nibble_t  nibble;

	logic [31:0]  lfsr;
	logic [31:0]  data;
	int           mismatch_errs;
	int           protocol_errs;
	pad_buttons_t host_pads [`PAD_PORTS];
	pad_word_t    snap_words [`PAD_PORTS];
	pad_cfg_t     cfg_m;
	logic         half_m;

	pce_pad_top u_pce_pad_top (
		.clk_sys (clk_sys),
		.reset   (reset),
		.aw      (aw),
		.awready (awready),
		.w       (w),
		.wready  (wready),
		.b       (b),
		.bready  (bready),
		.ar      (ar),
		.arready (arready),
		.r       (r),
		.rready  (rready),
		.scan    (scan),
		.nibble  (nibble)
	);

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// Protocol and scan properties
	//////////////////////////////////////////////////

	assert property (@(posedge clk_sys) disable iff (reset) (b.valid && !bready) |=> b.valid)
		else begin
			$display("bvalid dropped before bready was seen");
			protocol_errs++;
		end

	assert property (@(posedge clk_sys) disable iff (reset)
		(b.valid || r.valid) |-> !(awready || wready || arready))
		else begin
			$display("new request accepted while a response was pending");
			protocol_errs++;
		end

	// Nibble is forced low one clock after CLR is sampled high
	assert property (@(posedge clk_sys) disable iff (reset) scan.clr |=> (nibble == 4'h0))
		else begin
			$display("mismatch nibble: got 0x%0h expected 0x0", $sampled(nibble));
			mismatch_errs++;
		end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// Pad word from the console layout, a pressed button pulls its line low
	function automatic pad_word_t expect_word(input pad_buttons_t v);
		pad_word_t wd;
		// Slot 0 from bit 0 up is I, II, Select, Run
		for (int i = 0; i < 4; i++) begin
			wd[i] = !v[4 + i];
		end
		// Slot 1 from bit 4 up is up, right, down, left
		wd[4] = !v[3];
		wd[5] = !v[0];
		wd[6] = !v[2];
		wd[7] = !v[1];
		// Slot 2 from bit 8 up is III to VI
		for (int i = 0; i < 4; i++) begin
			wd[8 + i] = !v[8 + i];
		end
		// Slot 3 is the inverted all-ones ID
		wd[15:12] = 4'h0;
		return wd;
	endfunction

	task automatic rand_word(output logic [31:0] v);
		for (int i = 0; i < 32; i++) begin
			lfsr = next_lfsr(lfsr);
			v[i] = lfsr[0];
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
			mismatch_errs++;
		end
	endtask

	task automatic timeout_abort(input string what);
		$display("timeout waiting for %s", what);
		$display("errors: %0d mismatch, %0d protocol", mismatch_errs, protocol_errs);
		$display("Checks failed");
		$finish;
	endtask

	task automatic write_request(input axil_addr_t addr, input axil_data_t wdata);
		int n;
		n = 0;
		aw = '{valid: 1'b1, addr: addr};
		w  = '{valid: 1'b1, data: wdata};
		@(negedge clk_sys);
		while (!(awready && wready)) begin
			n++;
			if (n > wait_limit) begin
				timeout_abort("awready and wready");
			end
			@(negedge clk_sys);
		end
		@(posedge clk_sys);
		#1;
		aw.valid = 1'b0;
		w.valid  = 1'b0;
	endtask

	task automatic axil_write(input axil_addr_t addr, input axil_data_t wdata,
		input axil_resp_t exp);
		int n;
		n = 0;
		write_request(addr, wdata);
		@(negedge clk_sys);
		while (!b.valid) begin
			n++;
			if (n > wait_limit) begin
				timeout_abort("bvalid");
			end
			@(negedge clk_sys);
		end
		check_value("bresp", b.resp, exp);
		@(posedge clk_sys);
		#1;
	endtask

	task automatic read_expect(input axil_addr_t addr, input axil_data_t exp_data,
		input axil_resp_t exp_resp);
		int n;
		n = 0;
		ar = '{valid: 1'b1, addr: addr};
		@(negedge clk_sys);
		while (!arready) begin
			n++;
			if (n > wait_limit) begin
				timeout_abort("arready");
			end
			@(negedge clk_sys);
		end
		@(posedge clk_sys);
		#1;
		ar.valid = 1'b0;
		n = 0;
		@(negedge clk_sys);
		while (!r.valid) begin
			n++;
			if (n > wait_limit) begin
				timeout_abort("rvalid");
			end
			@(negedge clk_sys);
		end
		check_value("rdata", r.data, exp_data);
		check_value("rresp", r.resp, exp_resp);
		@(posedge clk_sys);
		#1;
	endtask

	task automatic set_cfg(input logic tap, input logic six);
		axil_write(`PAD_CFG_OFFSET, {30'd0, tap, six}, resp_okay);
		cfg_m = '{tap_en: tap, six_en: six};
	endtask

	// Nibble lands two edges after the lines change
	task automatic scan_read(input logic sel, input logic clr, input pad_nibble_t exp);
		scan = '{sel: sel, clr: clr};
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("nibble", nibble, exp);
		@(posedge clk_sys);
		#1;
	endtask

	// Start of a scan, snapshots follow the host registers
	task automatic clr_pulse();
		scan_read(1'b1, 1'b1, 4'h0);
		scan_read(1'b1, 1'b1, 4'h0);
		if (cfg_m.six_en) begin
			half_m = ~half_m;
		end else begin
			half_m = 1'b0;
		end
		for (int i = 0; i < `PAD_PORTS; i++) begin
			snap_words[i] = expect_word(host_pads[i]);
		end
	endtask

	// SEL high then low on one port, slot is 2*half + SEL
	task automatic read_port(input int port);
		pad_word_t wd;
		int        slot;
		wd = '1;
		if (port < `PAD_PORTS) begin
			wd = snap_words[port];
		end
		slot = 2 * half_m + 1;
		scan_read(1'b1, 1'b0, wd[slot*4 +: 4]);
		slot = 2 * half_m;
		scan_read(1'b0, 1'b0, wd[slot*4 +: 4]);
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		reset  = 1'b1;
		aw     = '0;
		w      = '0;
		ar     = '0;
		bready = 1'b1;
		rready = 1'b1;
		scan   = '{sel: 1'b1, clr: 1'b1};
		lfsr   = 32'ha692_6544;
		cfg_m  = '0;
		half_m = 1'b0;
		mismatch_errs = 0;
		protocol_errs = 0;
		for (int i = 0; i < `PAD_PORTS; i++) begin
			host_pads[i]  = '0;
			snap_words[i] = '1;
		end
		repeat (10) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		// Reset state
		@(negedge clk_sys);
		check_value("nibble", nibble, 4'h0);
		assert (!b.valid && !r.valid) else begin
			$display("response valid high after reset");
			protocol_errs++;
		end
		@(posedge clk_sys);
		#1;
		scan_read(1'b1, 1'b0, 4'hF);
		for (int i = 0; i < `PAD_PORTS; i++) begin
			read_expect(axil_addr_t'(i * `PAD_REG_STRIDE), 32'd0, resp_okay);
		end
		read_expect(`PAD_CFG_OFFSET, 32'd0, resp_okay);

		// Register write and read-back
		for (int i = 0; i < `PAD_PORTS; i++) begin
			rand_word(data);
			axil_write(axil_addr_t'(i * `PAD_REG_STRIDE), data, resp_okay);
			host_pads[i] = data[11:0];
			read_expect(axil_addr_t'(i * `PAD_REG_STRIDE), {20'd0, data[11:0]}, resp_okay);
		end
		read_expect(8'h40, 32'd0, resp_slverr);

		// Unmapped write with the response held back
		bready = 1'b0;
		write_request(8'h40, 32'hFFFF_FFFF);
		ar = '{valid: 1'b1, addr: 8'h00};
		repeat (4) begin
			@(negedge clk_sys);
			assert (b.valid && !arready) else begin
				$display("read accepted or bvalid dropped while bready held low");
				protocol_errs++;
			end
		end
		check_value("bresp", b.resp, resp_slverr);
		@(posedge clk_sys);
		#1;
		bready = 1'b1;
		read_expect(8'h00, {20'd0, host_pads[0]}, resp_okay);

		// Single port
		clr_pulse();
		read_port(0);
		read_port(0);

		// Multitap, the sixth port reads empty
		set_cfg(1'b1, 1'b0);
		clr_pulse();
		for (int p = 0; p <= `PAD_PORTS; p++) begin
			read_port(p);
		end

		// Six-button halves alternate per scan
		set_cfg(1'b1, 1'b1);
		for (int s = 0; s < 3; s++) begin
			clr_pulse();
			if (half_m) begin
				scan_read(1'b1, 1'b0, `PAD_ID_NIBBLE);
			end
			for (int p = 0; p <= `PAD_PORTS; p++) begin
				read_port(p);
			end
		end

		// Host write during a scan waits for the next one
		set_cfg(1'b0, 1'b0);
		clr_pulse();
		read_port(0);
		axil_write(8'h00, {20'd0, ~host_pads[0]}, resp_okay);
		host_pads[0] = ~host_pads[0];
		read_port(0);
		clr_pulse();
		read_port(0);

		$display("errors: %0d mismatch, %0d protocol", mismatch_errs, protocol_errs);
		if (mismatch_errs + protocol_errs == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* compile.f */
+incdir+source
source/axi_lite_pkg.sv
source/pad_pkg.sv
source/pad_host_regs.sv
source/pad_snapshot.sv
source/tap_scanner.sv
source/pce_pad_top.sv
dv/pce_pad_tb.sv
